// ==== common/ilemt_pkg.sv ====
`default_nettype none

package ilemt_pkg;

   // Word sizes shared by the register bus and both streams
   localparam int WORD_W = 32;
   localparam int BYTE_W = 8;

   // Byte lanes per register word, one wstrb bit each
   localparam int LANES = WORD_W / BYTE_W;

   // Register bank geometry
   // Fixed by the address map, 32 words of 32 bits
   localparam int LITE_WORDS = 32;
   localparam int LITE_ADDR_W = $clog2(LITE_WORDS);

   // Scratch RAM geometry, one byte per address
   localparam int MEM_WORDS = 32;
   localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

   // Default depth for capture and playback FIFOs
   // Has to stay a power of two
   localparam int FIFO_DEPTH = 16;

   // One register bus request per cycle
   // addr is a word index, the byte offset is already stripped
   typedef struct packed {
      logic                   wren;
      logic [LANES-1:0]       wstrb;
      logic                   rden;
      logic [LITE_ADDR_W-1:0] addr;
      logic [WORD_W-1:0]      wr_data;
   } lite_req_t;

   // One scratch RAM request per cycle
   typedef struct packed {
      logic                  wren;
      logic                  rden;
      logic [MEM_ADDR_W-1:0] addr;
      logic [BYTE_W-1:0]     wr_data;
   } mem_req_t;

   // Capture stream states
   // OVERFLOW is sticky until the host closes the stream
   typedef enum logic [1:0] {
      STREAM_CLOSED   = 2'd0,
      STREAM_RUN      = 2'd1,
      STREAM_OVERFLOW = 2'd2
   } stream_state_t;

endpackage

`default_nettype wire

// ==== source/lite_regs.sv ====
`default_nettype none

// Memory-mapped register bank
// Storage is split per byte lane so a partial write touches only its lanes
module lite_regs
(
   input  logic                         bus_clk,
   input  logic                         rst_n,
   input  ilemt_pkg::lite_req_t         lite_req,
   output logic [ilemt_pkg::WORD_W-1:0] rd_data
);

   // Lane l holds bits l*8+7 : l*8 of every word
   logic [ilemt_pkg::BYTE_W-1:0] lane_mem [ilemt_pkg::LANES][ilemt_pkg::LITE_WORDS];

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         // Whole bank reads zero after reset
         for (int l = 0; l < ilemt_pkg::LANES; l++)
         begin
            for (int w = 0; w < ilemt_pkg::LITE_WORDS; w++)
            begin
               lane_mem[l][w] <= '0;
            end
         end
         rd_data <= '0;
      end
      else
      begin
         // Each lane follows its own strobe
         for (int l = 0; l < ilemt_pkg::LANES; l++)
         begin
            if (lite_req.wren && lite_req.wstrb[l])
            begin
               lane_mem[l][lite_req.addr] <=
                  lite_req.wr_data[l*ilemt_pkg::BYTE_W +: ilemt_pkg::BYTE_W];
            end
         end

         // Registered read, data holds until the next rden
         if (lite_req.rden)
         begin
            for (int l = 0; l < ilemt_pkg::LANES; l++)
            begin
               rd_data[l*ilemt_pkg::BYTE_W +: ilemt_pkg::BYTE_W] <=
                  lane_mem[l][lite_req.addr];
            end
         end
      end
   end

   // Strobes only mean something together with wren
   // A stray strobe points to a broken bus master
   assert property (@(posedge bus_clk) disable iff (!rst_n)
      !lite_req.wren |-> (lite_req.wstrb == '0))
      else $error("lite_regs: wstrb %b seen without wren", lite_req.wstrb);

endmodule

`default_nettype wire

// ==== source/scratch_ram.sv ====
`default_nettype none

// Byte-wide scratch RAM for the host
// Single port with read-before-write behaviour
module scratch_ram
(
   input  logic                         bus_clk,
   input  logic                         rst_n,
   input  ilemt_pkg::mem_req_t          mem_req,
   output logic [ilemt_pkg::BYTE_W-1:0] rd_data
);

   logic [ilemt_pkg::BYTE_W-1:0] mem [ilemt_pkg::MEM_WORDS];

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int a = 0; a < ilemt_pkg::MEM_WORDS; a++)
         begin
            mem[a] <= '0;
         end
         rd_data <= '0;
      end
      else
      begin
         if (mem_req.wren)
         begin
            mem[mem_req.addr] <= mem_req.wr_data;
         end
         // Samples the array before this edge's write lands
         // so a same-address read returns the old byte
         if (mem_req.rden)
         begin
            rd_data <= mem[mem_req.addr];
         end
      end
   end

endmodule

`default_nettype wire

// ==== stream/sample_fifo.sv ====
`default_nettype none

// Synchronous word FIFO for the capture and playback streams
// Flags decode straight from the registered count
module sample_fifo
#(
   parameter int DEPTH = ilemt_pkg::FIFO_DEPTH
)
(
   input  logic                         bus_clk,
   input  logic                         rst_n,
   input  logic                         flush,
   input  logic                         wr_en,
   input  logic [ilemt_pkg::WORD_W-1:0] wr_data,
   input  logic                         rd_en,
   output logic [ilemt_pkg::WORD_W-1:0] rd_data,
   output logic                         full,
   output logic                         empty
);

   logic [ilemt_pkg::WORD_W-1:0] mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]     wr_ptr;
   logic [$clog2(DEPTH)-1:0]     rd_ptr;
   // One extra bit so a full FIFO is told apart from an empty one
   logic [$clog2(DEPTH):0]       count;
   logic                         do_wr;
   logic                         do_rd;

   // Pointers wrap by overflow, which only works for a power of two
   if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0)
   begin : g_depth_check
      $error("sample_fifo: DEPTH %0d is not a power of two", DEPTH);
   end

   assign full  = (count == ($clog2(DEPTH) + 1)'(DEPTH));
   assign empty = (count == '0);

   // Protect the pointers even if a side ignores the flags
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // Storage, no reset needed
   always_ff @(posedge bus_clk)
   begin
      if (do_wr)
      begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         rd_data <= '0;
      end
      else if (flush)
      begin
         // Flush drops everything, empty shows on the next edge
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd)
         begin
            rd_ptr  <= rd_ptr + 1'b1;
            rd_data <= mem[rd_ptr];
         end
         unique case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Writers must watch full
   assert property (@(posedge bus_clk) disable iff (!rst_n) wr_en |-> !full)
      else $error("sample_fifo: write while full");

   // Readers must watch empty
   assert property (@(posedge bus_clk) disable iff (!rst_n) rd_en |-> !empty)
      else $error("sample_fifo: read while empty");

endmodule

`default_nettype wire

// ==== stream/stream_control.sv ====
`default_nettype none

// Capture stream control
// Handles open and close, sample gating, sticky overflow and end-of-file
module stream_control
(
   input  logic bus_clk,
   input  logic rst_n,
   input  logic read_open,
   input  logic write_open,
   input  logic capture_en,
   input  logic adc_full,
   input  logic adc_empty,
   output logic adc_wr_en,
   output logic adc_flush,
   output logic dac_flush,
   output logic read_eof
);

   ilemt_pkg::stream_state_t state;
   ilemt_pkg::stream_state_t state_next;

   // Both FIFOs sit in flush while their device is closed
   assign adc_flush = !read_open;
   assign dac_flush = !write_open;

   // Combinational gate so the sample is written on the edge it arrives
   // Samples meeting a full FIFO are dropped
   assign adc_wr_en = capture_en && !adc_full && (state == ilemt_pkg::STREAM_RUN);

   // End-of-file once overflow happened and the host drained what was kept
   assign read_eof = (state == ilemt_pkg::STREAM_OVERFLOW) && adc_empty;

   always_comb
   begin
      state_next = state;
      unique case (state)
         ilemt_pkg::STREAM_CLOSED:
         begin
            // Leaving CLOSED marks the rising edge of read_open
            if (read_open)
            begin
               state_next = ilemt_pkg::STREAM_RUN;
            end
         end
         ilemt_pkg::STREAM_RUN:
         begin
            if (capture_en && adc_full)
            begin
               state_next = ilemt_pkg::STREAM_OVERFLOW;
            end
         end
         ilemt_pkg::STREAM_OVERFLOW:
         begin
            // Sticky, only a close gets out of here
            state_next = ilemt_pkg::STREAM_OVERFLOW;
         end
         default:
         begin
            state_next = ilemt_pkg::STREAM_CLOSED;
         end
      endcase
      // Close overrides every state
      if (!read_open)
      begin
         state_next = ilemt_pkg::STREAM_CLOSED;
      end
   end

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= ilemt_pkg::STREAM_CLOSED;
      end
      else
      begin
         state <= state_next;
      end
   end

   // No sample may reach the capture FIFO before the stream opens
   assert property (@(posedge bus_clk) disable iff (!rst_n)
      (state == ilemt_pkg::STREAM_CLOSED) |-> !adc_wr_en)
      else $error("stream_control: capture write while closed");

endmodule

`default_nettype wire

// ==== source/ilemt_host.sv ====
`default_nettype none

// Host-side fabric of the tracker board
// Register bank, scratch RAM, capture stream and playback stream on bus_clk
module ilemt_host
(
   input  logic                         bus_clk,
   input  logic                         rst_n,
   input  ilemt_pkg::lite_req_t         lite_req,
   output logic [ilemt_pkg::WORD_W-1:0] lite_rd_data,
   input  ilemt_pkg::mem_req_t          mem_req,
   output logic [ilemt_pkg::BYTE_W-1:0] mem_rd_data,
   input  logic                         capture_en,
   input  logic [ilemt_pkg::WORD_W-1:0] capture_data,
   input  logic                         read_open,
   input  logic                         read_rden,
   output logic [ilemt_pkg::WORD_W-1:0] read_data,
   output logic                         read_empty,
   output logic                         read_eof,
   input  logic                         write_open,
   input  logic                         write_wren,
   input  logic [ilemt_pkg::WORD_W-1:0] write_data,
   output logic                         write_full,
   input  logic                         dac_rden,
   output logic [ilemt_pkg::WORD_W-1:0] dac_data,
   output logic                         dac_empty
);

   // Capture side glue between control and FIFO
   logic adc_wr_en;
   logic adc_flush;
   logic adc_full;
   logic dac_flush;

   lite_regs i_lite_regs (
      .bus_clk (bus_clk),
      .rst_n   (rst_n),
      .lite_req(lite_req),
      .rd_data (lite_rd_data)
   );

   scratch_ram i_scratch_ram (
      .bus_clk(bus_clk),
      .rst_n  (rst_n),
      .mem_req(mem_req),
      .rd_data(mem_rd_data)
   );

   // read_empty feeds back so eof can wait for the drain
   stream_control i_stream_control (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .read_open (read_open),
      .write_open(write_open),
      .capture_en(capture_en),
      .adc_full  (adc_full),
      .adc_empty (read_empty),
      .adc_wr_en (adc_wr_en),
      .adc_flush (adc_flush),
      .dac_flush (dac_flush),
      .read_eof  (read_eof)
   );

   // ADC samples towards the host read stream
   sample_fifo #(.DEPTH(ilemt_pkg::FIFO_DEPTH)) adc_fifo (
      .bus_clk(bus_clk),
      .rst_n  (rst_n),
      .flush  (adc_flush),
      .wr_en  (adc_wr_en),
      .wr_data(capture_data),
      .rd_en  (read_rden),
      .rd_data(read_data),
      .full   (adc_full),
      .empty  (read_empty)
   );

   // Host write stream towards the DAC side
   sample_fifo #(.DEPTH(ilemt_pkg::FIFO_DEPTH)) dac_fifo (
      .bus_clk(bus_clk),
      .rst_n  (rst_n),
      .flush  (dac_flush),
      .wr_en  (write_wren),
      .wr_data(write_data),
      .rd_en  (dac_rden),
      .rd_data(dac_data),
      .full   (write_full),
      .empty  (dac_empty)
   );

endmodule

`default_nettype wire

// ==== sim/tb_ilemt_host.sv ====
`default_nettype none

// Testbench for the host-side fabric
// Reference models run beside the DUT and concurrent assertions compare every cycle
module tb_ilemt_host;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_TESTS = 6;
   localparam int DEPTH     = ilemt_pkg::FIFO_DEPTH;
   localparam int WORD_W    = ilemt_pkg::WORD_W;
   localparam int BYTE_W    = ilemt_pkg::BYTE_W;

   logic                 bus_clk;
   logic                 rst_n;
   ilemt_pkg::lite_req_t lite_req;
   logic [WORD_W-1:0]    lite_rd_data;
   ilemt_pkg::mem_req_t  mem_req;
   logic [BYTE_W-1:0]    mem_rd_data;
   logic                 capture_en;
   logic [WORD_W-1:0]    capture_data;
   logic                 read_open;
   logic                 read_rden;
   logic [WORD_W-1:0]    read_data;
   logic                 read_empty;
   logic                 read_eof;
   logic                 write_open;
   logic                 write_wren;
   logic [WORD_W-1:0]    write_data;
   logic                 write_full;
   logic                 dac_rden;
   logic [WORD_W-1:0]    dac_data;
   logic                 dac_empty;

   // Reference state
   logic [WORD_W-1:0]        reg_model [ilemt_pkg::LITE_WORDS];
   logic [BYTE_W-1:0]        ram_model [ilemt_pkg::MEM_WORDS];
   logic [WORD_W-1:0]        cap_q [$];
   logic [WORD_W-1:0]        play_q [$];
   ilemt_pkg::stream_state_t cap_st;

   // Expected outputs, valid after each edge
   logic [WORD_W-1:0] exp_lite_rd;
   logic [BYTE_W-1:0] exp_mem_rd;
   logic [WORD_W-1:0] exp_read_data;
   logic [WORD_W-1:0] exp_dac_data;
   logic              exp_read_empty;
   logic              exp_read_eof;
   logic              exp_write_full;
   logic              exp_dac_empty;
   // Read data is only compared in the cycle after a read strobe
   logic              read_chk;
   logic              dac_chk;

   int          errors      = 0;
   int          errors_mark = 0;
   int          tests_done  = 0;
   logic [31:0] rng         = 32'h64b4_f84f;

   ilemt_host i_dut (
      .bus_clk     (bus_clk),
      .rst_n       (rst_n),
      .lite_req    (lite_req),
      .lite_rd_data(lite_rd_data),
      .mem_req     (mem_req),
      .mem_rd_data (mem_rd_data),
      .capture_en  (capture_en),
      .capture_data(capture_data),
      .read_open   (read_open),
      .read_rden   (read_rden),
      .read_data   (read_data),
      .read_empty  (read_empty),
      .read_eof    (read_eof),
      .write_open  (write_open),
      .write_wren  (write_wren),
      .write_data  (write_data),
      .write_full  (write_full),
      .dac_rden    (dac_rden),
      .dac_data    (dac_data),
      .dac_empty   (dac_empty)
   );

   initial
   begin
      bus_clk = 1'b0;
      forever #10 bus_clk = ~bus_clk;
   end

   function automatic logic [31:0] lcg_next();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] observed);
      errors++;
      $display("ERROR at %0t: %s expected %h, observed %h", $time, name, expected, observed);
   endtask

   task automatic end_test(input string name);
      $display("Test %0d %s done at %0t, %0d errors", tests_done + 1, name, $time,
               errors - errors_mark);
      tests_done++;
      errors_mark = errors;
   endtask

   // Moves to 2 ns after the next rising edge
   task automatic tick();
      @(posedge bus_clk);
      #2;
   endtask

   always @(posedge bus_clk or negedge rst_n)
   begin : ref_model
      logic [WORD_W-1:0] word;
      logic              was_full;
      if (!rst_n)
      begin
         for (int i = 0; i < ilemt_pkg::LITE_WORDS; i++)
            reg_model[i] <= '0;
         for (int i = 0; i < ilemt_pkg::MEM_WORDS; i++)
            ram_model[i] <= '0;
         cap_q.delete();
         play_q.delete();
         cap_st         = ilemt_pkg::STREAM_CLOSED;
         exp_lite_rd    <= '0;
         exp_mem_rd     <= '0;
         exp_read_data  <= '0;
         exp_dac_data   <= '0;
         exp_read_empty <= 1'b1;
         exp_read_eof   <= 1'b0;
         exp_write_full <= 1'b0;
         exp_dac_empty  <= 1'b1;
         read_chk       <= 1'b0;
         dac_chk        <= 1'b0;
      end
      else
      begin
         // Register bank, lanes merge under their strobes
         word = reg_model[lite_req.addr];
         for (int l = 0; l < ilemt_pkg::LANES; l++)
            if (lite_req.wren && lite_req.wstrb[l])
               word[l*BYTE_W +: BYTE_W] = lite_req.wr_data[l*BYTE_W +: BYTE_W];
         reg_model[lite_req.addr] <= word;
         if (lite_req.rden)
            exp_lite_rd <= reg_model[lite_req.addr];

         // Scratch RAM returns the byte held before this edge
         if (mem_req.wren)
            ram_model[mem_req.addr] <= mem_req.wr_data;
         if (mem_req.rden)
            exp_mem_rd <= ram_model[mem_req.addr];

         // Capture stream
         read_chk <= 1'b0;
         if (!read_open)
         begin
            cap_q.delete();
            cap_st = ilemt_pkg::STREAM_CLOSED;
         end
         else
         begin
            was_full = (cap_q.size() == DEPTH);
            if (read_rden && cap_q.size() > 0)
            begin
               exp_read_data <= cap_q.pop_front();
               read_chk      <= 1'b1;
            end
            if (capture_en && cap_st == ilemt_pkg::STREAM_RUN)
            begin
               if (was_full)
                  cap_st = ilemt_pkg::STREAM_OVERFLOW;
               else
                  cap_q.push_back(capture_data);
            end
            // Open seen for the first time
            if (cap_st == ilemt_pkg::STREAM_CLOSED)
               cap_st = ilemt_pkg::STREAM_RUN;
         end
         exp_read_empty <= (cap_q.size() == 0);
         exp_read_eof   <= (cap_st == ilemt_pkg::STREAM_OVERFLOW) && (cap_q.size() == 0);

         // Playback stream
         dac_chk <= 1'b0;
         if (!write_open)
         begin
            play_q.delete();
         end
         else
         begin
            was_full = (play_q.size() == DEPTH);
            if (dac_rden && play_q.size() > 0)
            begin
               exp_dac_data <= play_q.pop_front();
               dac_chk      <= 1'b1;
            end
            if (write_wren && !was_full)
               play_q.push_back(write_data);
         end
         exp_write_full <= (play_q.size() == DEPTH);
         exp_dac_empty  <= (play_q.size() == 0);
      end
   end

   assert property (@(posedge bus_clk) disable iff (!rst_n) lite_rd_data == exp_lite_rd)
      else report_mismatch("lite_rd_data", $sampled(exp_lite_rd), $sampled(lite_rd_data));
   assert property (@(posedge bus_clk) disable iff (!rst_n) mem_rd_data == exp_mem_rd)
      else report_mismatch("mem_rd_data", 32'($sampled(exp_mem_rd)),
                           32'($sampled(mem_rd_data)));
   assert property (@(posedge bus_clk) disable iff (!rst_n) read_empty == exp_read_empty)
      else report_mismatch("read_empty", 32'($sampled(exp_read_empty)),
                           32'($sampled(read_empty)));
   assert property (@(posedge bus_clk) disable iff (!rst_n) read_eof == exp_read_eof)
      else report_mismatch("read_eof", 32'($sampled(exp_read_eof)), 32'($sampled(read_eof)));
   assert property (@(posedge bus_clk) disable iff (!rst_n)
      !read_chk || (read_data == exp_read_data))
      else report_mismatch("read_data", $sampled(exp_read_data), $sampled(read_data));
   assert property (@(posedge bus_clk) disable iff (!rst_n) write_full == exp_write_full)
      else report_mismatch("write_full", 32'($sampled(exp_write_full)),
                           32'($sampled(write_full)));
   assert property (@(posedge bus_clk) disable iff (!rst_n) dac_empty == exp_dac_empty)
      else report_mismatch("dac_empty", 32'($sampled(exp_dac_empty)),
                           32'($sampled(dac_empty)));
   assert property (@(posedge bus_clk) disable iff (!rst_n)
      !dac_chk || (dac_data == exp_dac_data))
      else report_mismatch("dac_data", $sampled(exp_dac_data), $sampled(dac_data));

   // Reads the capture FIFO until it shows empty
   task automatic drain_capture();
      while (!read_empty)
      begin
         read_rden = 1'b1;
         tick();
      end
      read_rden = 1'b0;
      tick();
   endtask

   // Back-to-back capture pulses with fresh sample words
   task automatic capture_burst(input int n);
      for (int i = 0; i < n; i++)
      begin
         capture_en   = 1'b1;
         capture_data = lcg_next();
         tick();
      end
      capture_en = 1'b0;
   endtask

   task automatic test_regs();
      logic [31:0] r;
      // Random ops on words 0 to 7 so lanes overlap
      for (int i = 0; i < 24; i++)
      begin
         r = lcg_next();
         lite_req.wren    = r[0];
         lite_req.wstrb   = r[0] ? r[4:1] : '0;
         lite_req.rden    = r[5];
         lite_req.addr    = {2'b00, r[8:6]};
         lite_req.wr_data = lcg_next();
         tick();
      end
      lite_req = '0;
      // Full readback, untouched words read zero
      for (int a = 0; a < ilemt_pkg::LITE_WORDS; a++)
      begin
         lite_req.rden = 1'b1;
         lite_req.addr = 5'(a);
         tick();
      end
      lite_req = '0;
      tick();
      end_test("register bank");
   endtask

   task automatic test_ram();
      logic [31:0] r;
      for (int a = 0; a < ilemt_pkg::MEM_WORDS; a++)
      begin
         r = lcg_next();
         mem_req.wren    = 1'b1;
         mem_req.addr    = 5'(a);
         mem_req.wr_data = r[7:0];
         tick();
      end
      // Same-cycle read and write, old byte expected
      mem_req.rden    = 1'b1;
      mem_req.addr    = 5'd5;
      mem_req.wr_data = 8'h5a;
      tick();
      mem_req.addr    = 5'd20;
      mem_req.wr_data = 8'ha5;
      tick();
      mem_req.wren = 1'b0;
      for (int a = 0; a < ilemt_pkg::MEM_WORDS; a++)
      begin
         mem_req.addr = 5'(a);
         tick();
      end
      mem_req = '0;
      tick();
      end_test("scratch RAM");
   endtask

   task automatic test_capture_flow();
      logic [31:0] r;
      read_open = 1'b1;
      tick();
      for (int i = 0; i < 30; i++)
      begin
         r = lcg_next();
         capture_en   = r[0] && (i < 20);
         capture_data = lcg_next();
         // Reads only while data is present
         read_rden    = !read_empty && r[1];
         tick();
      end
      capture_en = 1'b0;
      drain_capture();
      end_test("capture flow");
   endtask

   task automatic test_overflow();
      // Stream left in RUN and empty by the previous test
      for (int i = 0; i < 20; i++)
      begin
         capture_en   = 1'b1;
         capture_data = lcg_next();
         tick();
      end
      capture_en = 1'b0;
      tick();
      drain_capture();
      tick();
      end_test("capture overflow");
   endtask

   task automatic test_reopen();
      // First close comes right after the overflow drain, eof has to fall
      read_open = 1'b0;
      tick();
      tick();
      read_open = 1'b1;
      tick();
      capture_burst(5);
      // Second close with samples still queued
      read_open = 1'b0;
      tick();
      tick();
      read_open = 1'b1;
      tick();
      capture_burst(5);
      drain_capture();
      end_test("capture reopen");
   endtask

   task automatic test_playback();
      write_open = 1'b1;
      tick();
      // Sixteen unread writes fill the FIFO
      for (int i = 0; i < DEPTH; i++)
      begin
         write_wren = !write_full;
         write_data = lcg_next();
         tick();
      end
      write_wren = 1'b0;
      tick();
      while (!dac_empty)
      begin
         dac_rden = 1'b1;
         tick();
      end
      dac_rden = 1'b0;
      for (int i = 0; i < 5; i++)
      begin
         write_wren = 1'b1;
         write_data = lcg_next();
         tick();
      end
      write_wren = 1'b0;
      // Close with words still queued
      write_open = 1'b0;
      tick();
      tick();
      end_test("playback");
   endtask

   initial
   begin
      rst_n        = 1'b0;
      lite_req     = '0;
      mem_req      = '0;
      capture_en   = 1'b0;
      capture_data = '0;
      read_open    = 1'b0;
      read_rden    = 1'b0;
      write_open   = 1'b0;
      write_wren   = 1'b0;
      write_data   = '0;
      dac_rden     = 1'b0;
      repeat (8) @(posedge bus_clk);
      #2;
      rst_n = 1'b1;
      tick();
      test_regs();
      test_ram();
      test_capture_flow();
      test_overflow();
      test_reopen();
      test_playback();
      $display("Tests run: %0d, errors: %0d", tests_done, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // 200 cycles per test on top of the reset time
   initial
   begin
      #((NUM_TESTS * 200 + 8) * 20);
      $display("Watchdog expired, the tests did not finish in time");
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/ilemt_pkg.sv
source/lite_regs.sv
source/scratch_ram.sv
stream/sample_fifo.sv
stream/stream_control.sv
source/ilemt_host.sv
sim/tb_ilemt_host.sv

// ==== Makefile ====
TOP  := tb_ilemt_host
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): verilog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f verilog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q '^Result: PASSED$$'

clean:
	rm -rf obj_dir
